// ==== eth_pkg.sv ====
// Shared types and helpers for the 10/100 Ethernet MAC with MII and frame FIFOs.
// Holds the byte beat struct used on every stream port, the FSM state
// enums of both MAC halves, the MII preamble constants and the nibble-wide
// CRC-32 used for FCS generation and checking.
// Modules pull it in with a wildcard import in their header.

package eth_pkg;

    // One byte of a frame on a valid/ready stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // Set on the last beat to mark the whole frame bad
        logic       user;
    } axis_beat_t;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_payload,
        tx_pad,
        tx_fcs,
        tx_gap
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_preamble,
        rx_payload,
        rx_drop
    } rx_state_t;

    // 15 of these, then the SFD nibble, make up preamble plus SFD
    localparam logic [3:0] eth_preamble_nibble = 4'h5;
    localparam logic [3:0] eth_sfd_nibble = 4'hd;

    // Bit-reversed form of 04C11DB7 for the LSB-first shift register
    localparam logic [31:0] crc_poly_rev = 32'hedb88320;

    // Register contents after a frame with a correct FCS, MSB-first view
    localparam logic [31:0] crc_residue = 32'hc704dd7b;

    // Advance the reflected CRC-32 by one nibble, bit 0 first
    function automatic logic [31:0] crc_nibble_next(input logic [31:0] crc,
                                                    input logic [3:0] nibble);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 4; i++) begin
            if (c[0] ^ nibble[i]) begin
                c = (c >> 1) ^ crc_poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== axis_frame_fifo.sv ====
// Store-and-forward frame FIFO for 8-bit beats with valid/ready handshake.
// A frame becomes visible on the output only once its last beat has been
// written with user clear. Bad frames and frames that run out of space are
// discarded by rewinding the write pointer, with a one-cycle status pulse.
// DEPTH is in beats and must be a power of two.

`timescale 1ns/1ps

module axis_frame_fifo
    import eth_pkg::*;
#(
    parameter int DEPTH = 2048
) (
    input  logic       logic_clk,
    input  logic       logic_rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       status_overflow,
    output logic       status_bad_frame,
    output logic       status_good_frame
);

    localparam int addr_w = $clog2(DEPTH);
    localparam logic [addr_w:0] ptr_wrap = {1'b1, {addr_w{1'b0}}};

    axis_beat_t mem [DEPTH];

    // Extra MSB on each pointer tells full from empty
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] commit_ptr;
    logic [addr_w:0] rd_ptr;
    logic            drop_frame;
    logic            wr_full;
    logic            commit_full;
    logic            wr_take;
    logic            wr_en;
    logic            rd_en;

    assign wr_full = (wr_ptr ^ rd_ptr) == ptr_wrap;
    assign commit_full = (commit_ptr ^ rd_ptr) == ptr_wrap;

    // Stall only when finished frames alone fill the memory
    assign in_ready = !commit_full;
    assign wr_take = in_valid && in_ready;
    assign wr_en = wr_take && !drop_frame && !wr_full;

    // Refill the output register when it is empty or being consumed
    assign rd_en = (commit_ptr != rd_ptr) && (!out_valid || out_ready);

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[addr_w-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[addr_w-1:0]];
        end
    end

    // Write side
    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            wr_ptr <= '0;
            commit_ptr <= '0;
            drop_frame <= 1'b0;
            status_overflow <= 1'b0;
            status_bad_frame <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            status_overflow <= 1'b0;
            status_bad_frame <= 1'b0;
            status_good_frame <= 1'b0;
            if (wr_take) begin
                if (in_beat.last) begin
                    drop_frame <= 1'b0;
                    if (drop_frame || wr_full) begin
                        wr_ptr <= commit_ptr;
                        status_overflow <= 1'b1;
                    end else if (in_beat.user) begin
                        wr_ptr <= commit_ptr;
                        status_bad_frame <= 1'b1;
                    end else begin
                        wr_ptr <= wr_ptr + 1'b1;
                        commit_ptr <= wr_ptr + 1'b1;
                        status_good_frame <= 1'b1;
                    end
                end else if (drop_frame || wr_full) begin
                    // Swallow the rest of an oversize frame
                    drop_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Read side, one registered output stage
    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            rd_ptr <= '0;
            out_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== eth_mac_mii_tx.sv ====
// MII transmit half of the MAC, one nibble per logic_clk cycle.
// Takes whole frames from the TX frame FIFO and sends preamble and SFD,
// the payload low nibble first, zero padding up to MIN_FRAME_LENGTH, the
// FCS and then holds tx_en low for the inter-frame gap.
// ifg_delay is the gap in bytes, two idle cycles each, never below 2 cycles.

`timescale 1ns/1ps

module eth_mac_mii_tx
    import eth_pkg::*;
#(
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  logic       logic_clk,
    input  logic       logic_rst_n,
    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [3:0] mii_txd,
    output logic       mii_tx_en,
    output logic       mii_tx_er,
    input  logic [7:0] ifg_delay
);

    // Minimum data length before the FCS
    localparam logic [15:0] min_data_len = 16'(MIN_FRAME_LENGTH - 4);

    tx_state_t   state;
    axis_beat_t  cur;
    logic        nib_sel;
    logic [3:0]  cnt;
    logic [15:0] byte_cnt;
    logic [8:0]  gap_cnt;
    logic [8:0]  gap_len;
    logic [31:0] crc;
    logic [31:0] crc_out;
    logic [3:0]  txd_next;

    assign gap_len = (ifg_delay == 8'd0) ? 9'd2 : {ifg_delay, 1'b0};
    assign crc_out = ~crc;

    always_comb begin
        case (state)
            tx_preamble: txd_next = (cnt == 4'd15) ? eth_sfd_nibble : eth_preamble_nibble;
            tx_payload:  txd_next = nib_sel ? cur.data[7:4] : cur.data[3:0];
            tx_fcs:      txd_next = crc_out[{cnt[2:0], 2'b00} +: 4];
            default:     txd_next = 4'h0;
        endcase
    end

    assign mii_txd = txd_next;
    assign mii_tx_en = state inside {tx_preamble, tx_payload, tx_pad, tx_fcs};
    // Store-and-forward source, so the line never underruns
    assign mii_tx_er = 1'b0;

    // First byte is taken in idle, the next ones on each high nibble
    assign in_ready = (state == tx_idle) ||
                      (state == tx_payload && nib_sel && !cur.last);

    always_ff @(posedge logic_clk) begin
        if (in_valid && in_ready) begin
            cur <= in_beat;
        end
    end

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            state <= tx_idle;
            nib_sel <= 1'b0;
            cnt <= '0;
            byte_cnt <= '0;
            gap_cnt <= '0;
            crc <= '1;
        end else begin
            case (state)
                tx_idle: begin
                    crc <= '1;
                    cnt <= '0;
                    nib_sel <= 1'b0;
                    byte_cnt <= '0;
                    if (in_valid) begin
                        state <= tx_preamble;
                    end
                end
                tx_preamble: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15) begin
                        state <= tx_payload;
                    end
                end
                tx_payload, tx_pad: begin
                    crc <= crc_nibble_next(crc, txd_next);
                    nib_sel <= !nib_sel;
                    if (nib_sel) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (state == tx_pad || cur.last) begin
                            // Pad short frames with zero bytes
                            state <= (byte_cnt + 16'd1 < min_data_len) ? tx_pad : tx_fcs;
                        end
                    end
                end
                tx_fcs: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd7) begin
                        state <= tx_gap;
                        gap_cnt <= gap_len - 1'b1;
                    end
                end
                tx_gap: begin
                    gap_cnt <= gap_cnt - 1'b1;
                    if (gap_cnt == '0) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// ==== eth_mac_mii_rx.sv ====
// MII receive half of the MAC, one nibble per logic_clk cycle.
// Strips preamble and SFD, rebuilds bytes low nibble first and checks the
// FCS over every nibble. Bytes pass through a short delay line so the four
// FCS bytes never reach the output. The last beat follows one cycle after
// rx_dv drops, with user set for a bad FCS, rx_er or a runt frame.

`timescale 1ns/1ps

module eth_mac_mii_rx
    import eth_pkg::*;
(
    input  logic       logic_clk,
    input  logic       logic_rst_n,
    input  logic [3:0] mii_rxd,
    input  logic       mii_rx_dv,
    input  logic       mii_rx_er,
    output axis_beat_t out_beat,
    output logic       out_valid,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs
);

    rx_state_t   state;
    logic [3:0]  lo_nib;
    logic        nib_sel;
    logic [7:0]  dly [4];
    logic [2:0]  dly_cnt;
    // Next byte to go out, held until the byte after it shows up
    logic [7:0]  hold;
    logic        hold_valid;
    logic        err_seen;
    logic [31:0] crc;
    logic [31:0] crc_rev;
    logic [7:0]  rx_byte;
    logic        byte_done;
    logic        frame_end;
    logic        fcs_bad;
    logic        frame_bad;

    assign crc_rev = {<<{crc}};
    assign rx_byte = {mii_rxd, lo_nib};
    assign byte_done = (state == rx_payload) && mii_rx_dv && nib_sel;
    assign frame_end = (state == rx_payload) && !mii_rx_dv;
    assign fcs_bad = crc_rev != crc_residue;
    // No held byte means four bytes or fewer, odd nibble count is misaligned
    assign frame_bad = fcs_bad || err_seen || !hold_valid || nib_sel;

    always_ff @(posedge logic_clk) begin
        if ((state == rx_payload) && mii_rx_dv && !nib_sel) begin
            lo_nib <= mii_rxd;
        end
        if (byte_done) begin
            dly[0] <= rx_byte;
            for (int i = 1; i < 4; i++) begin
                dly[i] <= dly[i-1];
            end
            if (dly_cnt == 3'd4) begin
                hold <= dly[3];
            end
            out_beat <= '{data: hold, last: 1'b0, user: 1'b0};
        end
        if (frame_end) begin
            out_beat <= '{data: hold_valid ? hold : 8'h00, last: 1'b1, user: frame_bad};
        end
    end

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            state <= rx_idle;
            nib_sel <= 1'b0;
            dly_cnt <= '0;
            hold_valid <= 1'b0;
            err_seen <= 1'b0;
            crc <= '1;
            out_valid <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs <= 1'b0;
            case (state)
                rx_idle: begin
                    nib_sel <= 1'b0;
                    dly_cnt <= '0;
                    hold_valid <= 1'b0;
                    err_seen <= 1'b0;
                    crc <= '1;
                    if (mii_rx_dv) begin
                        state <= (mii_rxd == eth_preamble_nibble) ? rx_preamble : rx_drop;
                    end
                end
                rx_preamble: begin
                    if (!mii_rx_dv) begin
                        state <= rx_idle;
                    end else if (mii_rxd == eth_sfd_nibble) begin
                        state <= rx_payload;
                    end else if (mii_rxd != eth_preamble_nibble) begin
                        state <= rx_drop;
                    end
                end
                rx_payload: begin
                    if (mii_rx_dv) begin
                        crc <= crc_nibble_next(crc, mii_rxd);
                        nib_sel <= !nib_sel;
                        if (mii_rx_er) begin
                            err_seen <= 1'b1;
                        end
                        if (nib_sel) begin
                            if (dly_cnt == 3'd4) begin
                                out_valid <= hold_valid;
                                hold_valid <= 1'b1;
                            end else begin
                                dly_cnt <= dly_cnt + 1'b1;
                            end
                        end
                    end else begin
                        // Carrier gone, close the frame
                        out_valid <= 1'b1;
                        rx_error_bad_fcs <= fcs_bad;
                        rx_error_bad_frame <= frame_bad;
                        state <= rx_idle;
                    end
                end
                rx_drop: begin
                    if (!mii_rx_dv) begin
                        state <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

// ==== eth_mac_mii_fifo.sv ====
// 10/100 Ethernet MAC with MII and a store-and-forward frame FIFO per side.
// User frames enter on tx_axis and leave on MII, received MII frames that
// pass the FCS check come out on rx_axis. Everything runs on logic_clk at
// one MII nibble per cycle, so all status outputs are single-cycle pulses.

`timescale 1ns/1ps

module eth_mac_mii_fifo
    import eth_pkg::*;
#(
    parameter int TX_FIFO_DEPTH = 2048,
    parameter int RX_FIFO_DEPTH = 2048,
    parameter int MIN_FRAME_LENGTH = 64
) (
    input  logic       logic_clk,
    input  logic       logic_rst_n,
    input  axis_beat_t tx_axis,
    input  logic       tx_axis_valid,
    output logic       tx_axis_ready,
    output axis_beat_t rx_axis,
    output logic       rx_axis_valid,
    input  logic       rx_axis_ready,
    input  logic [3:0] mii_rxd,
    input  logic       mii_rx_dv,
    input  logic       mii_rx_er,
    output logic [3:0] mii_txd,
    output logic       mii_tx_en,
    output logic       mii_tx_er,
    output logic       tx_fifo_overflow,
    output logic       tx_fifo_bad_frame,
    output logic       tx_fifo_good_frame,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs,
    output logic       rx_fifo_overflow,
    output logic       rx_fifo_bad_frame,
    output logic       rx_fifo_good_frame,
    input  logic [7:0] ifg_delay
);

    axis_beat_t tx_mac_beat;
    logic       tx_mac_valid;
    logic       tx_mac_ready;
    axis_beat_t rx_mac_beat;
    logic       rx_mac_valid;

    axis_frame_fifo #(
        .DEPTH(TX_FIFO_DEPTH)
    ) tx_fifo (
        .logic_clk(logic_clk),
        .logic_rst_n(logic_rst_n),
        .in_beat(tx_axis),
        .in_valid(tx_axis_valid),
        .in_ready(tx_axis_ready),
        .out_beat(tx_mac_beat),
        .out_valid(tx_mac_valid),
        .out_ready(tx_mac_ready),
        .status_overflow(tx_fifo_overflow),
        .status_bad_frame(tx_fifo_bad_frame),
        .status_good_frame(tx_fifo_good_frame)
    );

    eth_mac_mii_tx #(
        .MIN_FRAME_LENGTH(MIN_FRAME_LENGTH)
    ) i_eth_mac_mii_tx (
        .logic_clk(logic_clk),
        .logic_rst_n(logic_rst_n),
        .in_beat(tx_mac_beat),
        .in_valid(tx_mac_valid),
        .in_ready(tx_mac_ready),
        .mii_txd(mii_txd),
        .mii_tx_en(mii_tx_en),
        .mii_tx_er(mii_tx_er),
        .ifg_delay(ifg_delay)
    );

    eth_mac_mii_rx i_eth_mac_mii_rx (
        .logic_clk(logic_clk),
        .logic_rst_n(logic_rst_n),
        .mii_rxd(mii_rxd),
        .mii_rx_dv(mii_rx_dv),
        .mii_rx_er(mii_rx_er),
        .out_beat(rx_mac_beat),
        .out_valid(rx_mac_valid),
        .rx_error_bad_frame(rx_error_bad_frame),
        .rx_error_bad_fcs(rx_error_bad_fcs)
    );

    // The receive MAC cannot stall, full frames are dropped as overflow
    axis_frame_fifo #(
        .DEPTH(RX_FIFO_DEPTH)
    ) rx_fifo (
        .logic_clk(logic_clk),
        .logic_rst_n(logic_rst_n),
        .in_beat(rx_mac_beat),
        .in_valid(rx_mac_valid),
        .in_ready(),
        .out_beat(rx_axis),
        .out_valid(rx_axis_valid),
        .out_ready(rx_axis_ready),
        .status_overflow(rx_fifo_overflow),
        .status_bad_frame(rx_fifo_bad_frame),
        .status_good_frame(rx_fifo_good_frame)
    );

endmodule

// ==== eth_mac_chk.sv ====
// Protocol checker for the MII MAC with frame FIFOs.
// Bound to the top level, it watches reset behavior, the rx_axis stall
// rule, the inter-frame gap on mii_tx_en and the unused mii_tx_er line.

`timescale 1ns/1ps

module eth_mac_chk
    import eth_pkg::*;
(
    input logic       logic_clk,
    input logic       logic_rst_n,
    input axis_beat_t rx_axis,
    input logic       rx_axis_valid,
    input logic       rx_axis_ready,
    input logic       mii_tx_en,
    input logic       mii_tx_er,
    input logic [7:0] ifg_delay
);

    // Idle cycles seen since tx_en was last high, saturating
    logic [9:0] low_cnt;
    logic [9:0] min_gap;

    assign min_gap = (ifg_delay < 8'd1) ? 10'd2 : {1'b0, ifg_delay, 1'b0};

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            low_cnt <= '1;
        end else if (mii_tx_en) begin
            low_cnt <= '0;
        end else if (low_cnt != '1) begin
            low_cnt <= low_cnt + 10'd1;
        end
    end

    reset_quiet: assert property (@(posedge logic_clk)
        !logic_rst_n |-> !rx_axis_valid && !mii_tx_en)
        else $error("rx_axis_valid or mii_tx_en high during reset");

    rx_stall_hold: assert property (@(posedge logic_clk) disable iff (!logic_rst_n)
        rx_axis_valid && !rx_axis_ready |=> rx_axis_valid && $stable(rx_axis))
        else $error("rx_axis changed while stalled");

    tx_gap_min: assert property (@(posedge logic_clk) disable iff (!logic_rst_n)
        $rose(mii_tx_en) |-> low_cnt >= min_gap)
        else $error("inter-frame gap shorter than %0d cycles", min_gap);

    tx_er_low: assert property (@(posedge logic_clk) !mii_tx_er)
        else $error("mii_tx_er went high");

endmodule

bind eth_mac_mii_fifo eth_mac_chk i_eth_mac_chk (
    .logic_clk(logic_clk),
    .logic_rst_n(logic_rst_n),
    .rx_axis(rx_axis),
    .rx_axis_valid(rx_axis_valid),
    .rx_axis_ready(rx_axis_ready),
    .mii_tx_en(mii_tx_en),
    .mii_tx_er(mii_tx_er),
    .ifg_delay(ifg_delay)
);

// ==== tb_eth_mac_mii_fifo.sv ====
// Testbench for the MII MAC with frame FIFOs.
// MII transmit is looped back into receive, with a one-shot nibble flip and
// a forced rx_er for error cases. Received beats are matched against a queue
// of expected, zero-padded frames; status pulses are counted per test.

`timescale 1ns/1ps

module tb_eth_mac_mii_fifo
    import eth_pkg::*;
;

    localparam int min_frame_len = 64;
    localparam int pad_len = min_frame_len - 4;
    // 8 frames of roughly 250 cycles each, with a wide margin
    localparam int timeout_cycles = 8 * 250 * 10;

    logic       logic_clk;
    logic       logic_rst_n;
    axis_beat_t tx_axis;
    logic       tx_axis_valid;
    logic       tx_axis_ready;
    axis_beat_t rx_axis;
    logic       rx_axis_valid;
    logic       rx_axis_ready;
    logic [3:0] mii_txd;
    logic       mii_tx_en;
    logic       mii_tx_er;
    logic [3:0] mii_rxd;
    logic       mii_rx_dv;
    logic       mii_rx_er;
    logic [3:0] rx_mask;
    logic       force_er;
    logic [7:0] ifg_delay;
    logic       tx_fifo_overflow;
    logic       tx_fifo_bad_frame;
    logic       tx_fifo_good_frame;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic       rx_fifo_overflow;
    logic       rx_fifo_bad_frame;
    logic       rx_fifo_good_frame;

    integer seed = 32'h3de9_f9a9;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;
    logic [7:0] exp_data [$];
    logic       exp_last [$];

    // Pulse counters and a snapshot taken at the start of each test
    int n_tx_good = 0;
    int n_tx_bad = 0;
    int n_rx_good = 0;
    int n_rx_bad = 0;
    int n_bad_fcs = 0;
    int n_bad_frame = 0;
    int n_tx_starts = 0;
    int s_tx_good;
    int s_tx_bad;
    int s_rx_good;
    int s_rx_bad;
    int s_bad_fcs;
    int s_bad_frame;
    int s_tx_starts;
    int s_errors;
    logic tx_en_prev = 1'b0;

    // Loopback with error injection
    assign mii_rxd = mii_txd ^ rx_mask;
    assign mii_rx_dv = mii_tx_en;
    assign mii_rx_er = force_er;

    eth_mac_mii_fifo #(
        .TX_FIFO_DEPTH(2048),
        .RX_FIFO_DEPTH(2048),
        .MIN_FRAME_LENGTH(min_frame_len)
    ) i_eth_mac_mii_fifo (.*);

    initial begin
        logic_clk = 1'b0;
        forever #5 logic_clk = ~logic_clk;
    end

    initial begin
        rx_axis_ready = 1'b0;
        forever begin
            @(posedge logic_clk);
            #1;
            rx_axis_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        while (cycles < timeout_cycles) begin
            @(posedge logic_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [7:0] payload_byte(input int fid, input int idx);
        return 8'((idx * 13) + (fid * 37) + 1);
    endfunction

    // Outputs are stable at the falling edge
    always @(negedge logic_clk) begin
        logic [7:0] d;
        logic       l;
        if (logic_rst_n) begin
            n_tx_good += int'(tx_fifo_good_frame);
            n_tx_bad += int'(tx_fifo_bad_frame);
            n_rx_good += int'(rx_fifo_good_frame);
            n_rx_bad += int'(rx_fifo_bad_frame);
            n_bad_fcs += int'(rx_error_bad_fcs);
            n_bad_frame += int'(rx_error_bad_frame);
            n_tx_starts += int'(mii_tx_en && !tx_en_prev);
            tx_en_prev = mii_tx_en;
            assert (!tx_fifo_overflow && !rx_fifo_overflow) else begin
                $display("FIFO overflow pulse seen although no frame was oversize");
                errors++;
            end
            if (rx_axis_valid && rx_axis_ready) begin
                checks++;
                assert (exp_data.size() > 0) else begin
                    $display("Beat arrived on rx_axis while no frame was expected");
                    errors++;
                end
                if (exp_data.size() > 0) begin
                    d = exp_data.pop_front();
                    l = exp_last.pop_front();
                    assert (rx_axis.data == d) else begin
                        $display("FAIL rx_axis.data: got 0x%02h expected 0x%02h",
                                 rx_axis.data, d);
                        errors++;
                    end
                    assert (rx_axis.last == l) else begin
                        $display("FAIL rx_axis.last: got 0x%0h expected 0x%0h",
                                 rx_axis.last, l);
                        errors++;
                    end
                    assert (rx_axis.user == 1'b0) else begin
                        $display("FAIL rx_axis.user: got 0x%0h expected 0x0", rx_axis.user);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic take_snapshot();
        s_tx_good = n_tx_good;
        s_tx_bad = n_tx_bad;
        s_rx_good = n_rx_good;
        s_rx_bad = n_rx_bad;
        s_bad_fcs = n_bad_fcs;
        s_bad_frame = n_bad_frame;
        s_tx_starts = n_tx_starts;
        s_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: done, %0d errors", tests, name, errors - s_errors);
    endtask

    task automatic expect_frame(input int fid, input int len);
        int n;
        n = (len < pad_len) ? pad_len : len;
        for (int i = 0; i < n; i++) begin
            exp_data.push_back((i < len) ? payload_byte(fid, i) : 8'h00);
            exp_last.push_back(i == n - 1);
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_frame(input int fid, input int len, input logic bad);
        logic taken;
        for (int i = 0; i < len; i++) begin
            tx_axis.data = payload_byte(fid, i);
            tx_axis.last = (i == len - 1);
            tx_axis.user = bad && (i == len - 1);
            tx_axis_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge logic_clk);
                taken = tx_axis_ready;
                @(posedge logic_clk);
                #1;
            end
        end
        tx_axis_valid = 1'b0;
        tx_axis = '0;
    endtask

    task automatic wait_rx_drained();
        while (exp_data.size() != 0) begin
            @(posedge logic_clk);
        end
        #1;
    endtask

    task automatic wait_tx_start();
        while (n_tx_starts == s_tx_starts) begin
            @(posedge logic_clk);
        end
        // Land well inside the payload nibbles
        repeat (40) @(posedge logic_clk);
        #1;
    endtask

    task automatic wait_rx_bad();
        while (n_rx_bad == s_rx_bad) begin
            @(posedge logic_clk);
        end
        #1;
    endtask

    initial begin
        logic_rst_n = 1'b0;
        tx_axis = '0;
        tx_axis_valid = 1'b0;
        rx_mask = 4'h0;
        force_er = 1'b0;
        ifg_delay = 8'd12;
        repeat (8) @(posedge logic_clk);
        #1;
        logic_rst_n = 1'b1;
        repeat (4) @(posedge logic_clk);
        #1;

        take_snapshot();
        expect_frame(1, 100);
        send_frame(1, 100, 1'b0);
        wait_rx_drained();
        check_count("tx_fifo_good_frame pulses", n_tx_good - s_tx_good, 1);
        check_count("rx_fifo_good_frame pulses", n_rx_good - s_rx_good, 1);
        end_test("100-byte frame loopback");

        take_snapshot();
        expect_frame(2, 20);
        send_frame(2, 20, 1'b0);
        wait_rx_drained();
        check_count("rx_fifo_good_frame pulses", n_rx_good - s_rx_good, 1);
        end_test("short frame padding");

        take_snapshot();
        send_frame(3, 30, 1'b1);
        while (n_tx_bad == s_tx_bad) begin
            @(posedge logic_clk);
        end
        repeat (50) @(posedge logic_clk);
        #1;
        check_count("tx_fifo_bad_frame pulses", n_tx_bad - s_tx_bad, 1);
        check_count("mii_tx_en starts", n_tx_starts - s_tx_starts, 0);
        end_test("bad frame dropped on TX");

        take_snapshot();
        send_frame(4, 64, 1'b0);
        wait_tx_start();
        rx_mask = 4'h4;
        @(posedge logic_clk);
        #1;
        rx_mask = 4'h0;
        wait_rx_bad();
        check_count("rx_error_bad_fcs pulses", n_bad_fcs - s_bad_fcs, 1);
        check_count("rx_fifo_good_frame pulses", n_rx_good - s_rx_good, 0);
        end_test("corrupted nibble");

        take_snapshot();
        send_frame(5, 64, 1'b0);
        wait_tx_start();
        force_er = 1'b1;
        @(posedge logic_clk);
        #1;
        force_er = 1'b0;
        wait_rx_bad();
        check_count("rx_error_bad_frame pulses", n_bad_frame - s_bad_frame, 1);
        check_count("rx_error_bad_fcs pulses", n_bad_fcs - s_bad_fcs, 0);
        end_test("rx_er frame");

        take_snapshot();
        expect_frame(6, 70);
        expect_frame(7, 45);
        expect_frame(8, 120);
        send_frame(6, 70, 1'b0);
        send_frame(7, 45, 1'b0);
        send_frame(8, 120, 1'b0);
        wait_rx_drained();
        check_count("mii_tx_en starts", n_tx_starts - s_tx_starts, 3);
        check_count("rx_fifo_good_frame pulses", n_rx_good - s_rx_good, 3);
        end_test("back-to-back frames");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
eth_pkg.sv
axis_frame_fifo.sv
eth_mac_mii_tx.sv
eth_mac_mii_rx.sv
eth_mac_mii_fifo.sv
eth_mac_chk.sv
tb_eth_mac_mii_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_eth_mac_mii_fifo -f build.f \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_eth_mac_mii_fifo >> sim.log 2>&1
cat sim.log
grep -q "^All checks passed$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
